// ==== rtl/minv_macros.svh ====
// matrix order and Q8.8 word format for the matrix inverter
`ifndef MINV_MACROS_SVH
`define MINV_MACROS_SVH

// only 3x3 is supported by the stage sequencing
`define MINV_N 3

// word width and binary point position
`define MINV_W 16
`define MINV_FRAC 8

`endif

// ==== rtl/minv_pkg.sv ====
// fixed-point, index, matrix and state types for the inverter
// plus the shared Q8.8 multiply and entry index helpers
`include "minv_macros.svh"

package minv_pkg;

	typedef logic signed [`MINV_W-1:0] fx_t;
	typedef logic signed [2*`MINV_W-1:0] prod_t;
	typedef logic [$clog2(`MINV_N)-1:0] idx_t;
	typedef logic [$clog2(`MINV_N*`MINV_N)-1:0] ent_t;

	// row-major, entry (r,c) sits at e[r*N+c]
	typedef struct packed {
		fx_t [`MINV_N*`MINV_N-1:0] e;
	} mat_t;

	// lower triangle plus reciprocals of its diagonal
	typedef struct packed {
		mat_t l;
		fx_t [`MINV_N-1:0] r;
	} chol_t;

	typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;
	typedef enum logic [2:0] {
		chol_idle, chol_diag, chol_sqrt_wait, chol_recip_wait, chol_offdiag, chol_out
	} chol_state_e;
	typedef enum logic [1:0] {seq_idle, seq_calc, seq_out} seq_state_e;

	// full product, arithmetic shift, keep low word
	function automatic fx_t fx_mul(fx_t a, fx_t b);
		prod_t p;
		p = prod_t'(a) * prod_t'(b);
		return fx_t'(p >>> `MINV_FRAC);
	endfunction

	function automatic ent_t ent_idx(idx_t row, idx_t col);
		return ent_t'(row) * ent_t'(`MINV_N) + ent_t'(col);
	endfunction

endpackage

// ==== rtl/fx_div.sv ====
// sequential restoring divider for signed Q8.8, truncating toward zero
`include "minv_macros.svh"

module fx_div (
	input  logic          i,
	input  logic          rst_n,
	input  logic          start,
	input  minv_pkg::fx_t dividend,
	input  minv_pkg::fx_t divisor,
	output minv_pkg::fx_t quotient,
	output logic          done
);
	import minv_pkg::*;

	localparam int steps = `MINV_W + 1;
	localparam int cw = $clog2(steps);

	div_state_e state;
	logic [cw-1:0] cnt;
	logic [`MINV_W-1:0] num_mag;
	logic [`MINV_W+`MINV_FRAC-1:0] num_wide;
	logic [`MINV_W+1:0] den;
	logic [`MINV_W+1:0] rem;
	logic [`MINV_W+1:0] rem_sh;
	logic [`MINV_W+1:0] rem_next;
	logic [`MINV_W:0] q;
	logic [`MINV_W:0] q_next;
	logic neg;

	// magnitudes, sign restored at the end
	assign num_mag = dividend[`MINV_W-1] ? -dividend : dividend;
	assign num_wide = {num_mag, {`MINV_FRAC{1'b0}}};

	// shift in the next dividend bit and try the subtraction
	assign rem_sh = {rem[`MINV_W:0], q[`MINV_W]};
	assign rem_next = (rem_sh >= den) ? rem_sh - den : rem_sh;
	assign q_next = {q[`MINV_W-1:0], rem_sh >= den};

	assign done = (state == div_done);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state <= div_idle;
			cnt <= '0;
		end else begin
			case (state)
				div_idle: begin
					if (start) begin
						// upper bits seed the remainder, quotient fits in 17 bits
						rem <= (`MINV_W+2)'(num_wide >> steps);
						q <= num_wide[steps-1:0];
						den <= (`MINV_W+2)'(divisor[`MINV_W-1] ? -divisor : divisor);
						neg <= dividend[`MINV_W-1] ^ divisor[`MINV_W-1];
						cnt <= '0;
						state <= div_run;
					end
				end
				div_run: begin
					rem <= rem_next;
					q <= q_next;
					cnt <= cnt + 1'b1;
					if (cnt == cw'(steps - 1)) begin
						quotient <= neg ? fx_t'(-q_next[`MINV_W-1:0]) : fx_t'(q_next[`MINV_W-1:0]);
						state <= div_done;
					end
				end
				default: state <= div_idle;
			endcase
		end
	end

endmodule

// ==== rtl/fx_sqrt.sv ====
// sequential non-restoring square root, floor of sqrt(radicand << 8)
`include "minv_macros.svh"

module fx_sqrt (
	input  logic          i,
	input  logic          rst_n,
	input  logic          start,
	input  minv_pkg::fx_t radicand,
	output minv_pkg::fx_t root,
	output logic          done
);
	import minv_pkg::*;

	localparam int xw = `MINV_W + `MINV_FRAC;
	localparam int rw = xw / 2;
	localparam int cw = $clog2(rw);

	logic [xw-1:0] x;
	logic [rw-1:0] q;
	logic signed [`MINV_W+1:0] rem;
	logic signed [`MINV_W+1:0] rem_sh;
	logic signed [`MINV_W+1:0] rem_next;
	logic [cw-1:0] cnt;
	logic busy;

	// bring down the next bit pair
	assign rem_sh = {rem[`MINV_W-1:0], x[xw-1 -: 2]};

	// negative remainder adds back, otherwise subtract the trial term
	assign rem_next = rem[`MINV_W+1] ? rem_sh + (`MINV_W+2)'({q, 2'b11})
		: rem_sh - (`MINV_W+2)'({q, 2'b01});

	assign root = fx_t'(q);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				// radicand taken as unsigned bits
				x <= {radicand, {`MINV_FRAC{1'b0}}};
				q <= '0;
				rem <= '0;
				cnt <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				x <= x << 2;
				rem <= rem_next;
				q <= {q[rw-2:0], ~rem_next[`MINV_W+1]};
				cnt <= cnt + 1'b1;
				if (cnt == cw'(rw - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== rtl/chol_stage.sv ====
// Cholesky stage, produces L and the reciprocals of its diagonal
// column by column with one multiplier, one square root and one divider
`include "minv_macros.svh"

module chol_stage (
	input  logic            i,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  minv_pkg::mat_t  in_mat,
	output logic            out_valid,
	input  logic            out_ready,
	output minv_pkg::chol_t out_chol
);
	import minv_pkg::*;

	localparam idx_t last = idx_t'(`MINV_N - 1);
	localparam fx_t fx_one = fx_t'(1 << `MINV_FRAC);

	chol_state_e state;
	idx_t col;
	idx_t row;
	idx_t k;
	mat_t a;
	mat_t l;
	fx_t [`MINV_N-1:0] r;
	fx_t acc;
	fx_t mul_a;
	fx_t mul_b;
	fx_t mul_p;
	fx_t sq_root;
	fx_t dv_quot;
	logic sq_start;
	logic sq_done;
	logic dv_start;
	logic dv_done;

	assign in_ready = (state == chol_idle);
	assign out_valid = (state == chol_out);
	assign out_chol.l = l;
	assign out_chol.r = r;

	// shared multiplier, final off-diagonal step scales by r_col
	always_comb begin
		if (state == chol_offdiag && k == col) begin
			mul_a = acc;
			mul_b = r[col];
		end else if (state == chol_offdiag) begin
			mul_a = l.e[ent_idx(row, k)];
			mul_b = l.e[ent_idx(col, k)];
		end else begin
			mul_a = l.e[ent_idx(col, k)];
			mul_b = l.e[ent_idx(col, k)];
		end
	end
	assign mul_p = fx_mul(mul_a, mul_b);

	assign sq_start = (state == chol_diag) && (k == col);
	assign dv_start = (state == chol_sqrt_wait) && sq_done;

	fx_sqrt u_sqrt (
		.i(i),
		.rst_n(rst_n),
		.start(sq_start),
		.radicand(acc),
		.root(sq_root),
		.done(sq_done)
	);

	// reciprocal of the new diagonal, straight from the root
	fx_div u_div (
		.i(i),
		.rst_n(rst_n),
		.start(dv_start),
		.dividend(fx_one),
		.divisor(sq_root),
		.quotient(dv_quot),
		.done(dv_done)
	);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state <= chol_idle;
			col <= '0;
			row <= '0;
			k <= '0;
		end else begin
			case (state)
				chol_idle: begin
					if (in_valid) begin
						a <= in_mat;
						l <= '0;
						col <= '0;
						k <= '0;
						acc <= in_mat.e[0];
						state <= chol_diag;
					end
				end
				chol_diag: begin
					if (k == col) begin
						state <= chol_sqrt_wait;
					end else begin
						acc <= acc - mul_p;
						k <= k + 1'b1;
					end
				end
				chol_sqrt_wait: begin
					if (sq_done) begin
						l.e[ent_idx(col, col)] <= sq_root;
						state <= chol_recip_wait;
					end
				end
				chol_recip_wait: begin
					if (dv_done) begin
						r[col] <= dv_quot;
						if (col == last) begin
							state <= chol_out;
						end else begin
							row <= col + 1'b1;
							k <= '0;
							acc <= a.e[ent_idx(col + 1'b1, col)];
							state <= chol_offdiag;
						end
					end
				end
				chol_offdiag: begin
					if (k == col) begin
						l.e[ent_idx(row, col)] <= mul_p;
						k <= '0;
						if (row == last) begin
							col <= col + 1'b1;
							acc <= a.e[ent_idx(col + 1'b1, col + 1'b1)];
							state <= chol_diag;
						end else begin
							row <= row + 1'b1;
							acc <= a.e[ent_idx(row + 1'b1, col)];
						end
					end else begin
						acc <= acc - mul_p;
						k <= k + 1'b1;
					end
				end
				chol_out: begin
					if (out_ready) begin
						state <= chol_idle;
					end
				end
				default: state <= chol_idle;
			endcase
		end
	end

endmodule

// ==== rtl/tri_inv_stage.sv ====
// forward substitution stage, inverts the lower triangle L
`include "minv_macros.svh"

module tri_inv_stage (
	input  logic            i,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  minv_pkg::chol_t in_chol,
	output logic            out_valid,
	input  logic            out_ready,
	output minv_pkg::mat_t  out_linv
);
	import minv_pkg::*;

	localparam idx_t last = idx_t'(`MINV_N - 1);

	seq_state_e state;
	idx_t row;
	idx_t col;
	idx_t k;
	mat_t l;
	mat_t m;
	fx_t [`MINV_N-1:0] r;
	fx_t acc;
	fx_t mul_a;
	fx_t mul_b;
	fx_t mul_p;

	assign in_ready = (state == seq_idle);
	assign out_valid = (state == seq_out);
	assign out_linv = m;

	// sum of L_row,k * M_k,col, then scaled by r_row
	always_comb begin
		if (k == row) begin
			mul_a = acc;
			mul_b = r[row];
		end else begin
			mul_a = l.e[ent_idx(row, k)];
			mul_b = m.e[ent_idx(k, col)];
		end
	end
	assign mul_p = fx_mul(mul_a, mul_b);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state <= seq_idle;
			row <= '0;
			col <= '0;
			k <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (in_valid) begin
						l <= in_chol.l;
						r <= in_chol.r;
						// diagonal of the inverse is just r
						m <= '0;
						for (int n = 0; n < `MINV_N; n++) begin
							m.e[n * (`MINV_N + 1)] <= in_chol.r[n];
						end
						row <= idx_t'(1);
						col <= '0;
						k <= '0;
						acc <= '0;
						state <= seq_calc;
					end
				end
				seq_calc: begin
					if (k == row) begin
						m.e[ent_idx(row, col)] <= -mul_p;
						acc <= '0;
						// row by row, so every M_k,col needed is already done
						if (col + 1'b1 < row) begin
							col <= col + 1'b1;
							k <= col + 1'b1;
						end else if (row != last) begin
							row <= row + 1'b1;
							col <= '0;
							k <= '0;
						end else begin
							state <= seq_out;
						end
					end else begin
						acc <= acc + mul_p;
						k <= k + 1'b1;
					end
				end
				seq_out: begin
					if (out_ready) begin
						state <= seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

// ==== rtl/gram_stage.sv ====
// product of the transposed inverse triangle with itself
// six distinct entries on one multiply-accumulate, mirrored on write
`include "minv_macros.svh"

module gram_stage (
	input  logic           i,
	input  logic           rst_n,
	input  logic           in_valid,
	output logic           in_ready,
	input  minv_pkg::mat_t in_linv,
	output logic           out_valid,
	input  logic           out_ready,
	output minv_pkg::mat_t out_inv
);
	import minv_pkg::*;

	localparam idx_t last = idx_t'(`MINV_N - 1);

	seq_state_e state;
	idx_t row;
	idx_t col;
	idx_t k;
	mat_t m;
	mat_t res;
	fx_t acc;
	fx_t mul_p;
	fx_t sum;

	assign in_ready = (state == seq_idle);
	assign out_valid = (state == seq_out);
	assign out_inv = res;

	// M_k,row * M_k,col, k starts at col since row <= col
	assign mul_p = fx_mul(m.e[ent_idx(k, row)], m.e[ent_idx(k, col)]);
	assign sum = acc + mul_p;

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state <= seq_idle;
			row <= '0;
			col <= '0;
			k <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (in_valid) begin
						m <= in_linv;
						row <= '0;
						col <= '0;
						k <= '0;
						acc <= '0;
						state <= seq_calc;
					end
				end
				seq_calc: begin
					if (k == last) begin
						res.e[ent_idx(row, col)] <= sum;
						res.e[ent_idx(col, row)] <= sum;
						acc <= '0;
						if (col != last) begin
							col <= col + 1'b1;
							k <= col + 1'b1;
						end else if (row != last) begin
							row <= row + 1'b1;
							col <= row + 1'b1;
							k <= row + 1'b1;
						end else begin
							state <= seq_out;
						end
					end else begin
						acc <= sum;
						k <= k + 1'b1;
					end
				end
				seq_out: begin
					if (out_ready) begin
						state <= seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

// ==== rtl/minv_top.sv ====
// matrix inverter top, Cholesky -> triangle inverse -> Gram product
module minv_top (
	input  logic           i,
	input  logic           rst_n,
	input  logic           in_valid,
	output logic           in_ready,
	input  minv_pkg::mat_t in_mat,
	output logic           out_valid,
	input  logic           out_ready,
	output minv_pkg::mat_t out_mat
);
	import minv_pkg::*;

	chol_t chol_data;
	logic chol_valid;
	logic chol_ready;
	mat_t linv_data;
	logic linv_valid;
	logic linv_ready;

	chol_stage u_chol (
		.i(i),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_mat(in_mat),
		.out_valid(chol_valid),
		.out_ready(chol_ready),
		.out_chol(chol_data)
	);

	tri_inv_stage u_tri_inv (
		.i(i),
		.rst_n(rst_n),
		.in_valid(chol_valid),
		.in_ready(chol_ready),
		.in_chol(chol_data),
		.out_valid(linv_valid),
		.out_ready(linv_ready),
		.out_linv(linv_data)
	);

	gram_stage u_gram (
		.i(i),
		.rst_n(rst_n),
		.in_valid(linv_valid),
		.in_ready(linv_ready),
		.in_linv(linv_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_inv(out_mat)
	);

endmodule

// ==== test/minv_monitor.sv ====
// result monitor, compares each output transfer with the next expected matrix
`include "minv_macros.svh"

module minv_monitor (
	input logic           i,
	input logic           rst_n,
	input logic           out_valid,
	input logic           out_ready,
	input minv_pkg::mat_t out_mat
);
	import minv_pkg::*;

	string name_q[$];
	mat_t exp_q[$];
	int err_count = 0;
	int seen = 0;

	task automatic expect_result(input string name, input mat_t m);
		name_q.push_back(name);
		exp_q.push_back(m);
	endtask

	task automatic compare_result(input mat_t act);
		string name;
		mat_t exp;
		int n;
		if (exp_q.size() == 0) begin
			$display("a result came out while no matrix was pending");
			err_count++;
			return;
		end
		name = name_q.pop_front();
		exp = exp_q.pop_front();
		seen++;
		for (int r = 0; r < `MINV_N; r++) begin
			for (int c = 0; c < `MINV_N; c++) begin
				n = r * `MINV_N + c;
				if (act.e[n] !== exp.e[n]) begin
					$display("FAIL %s entry (%0d,%0d): expected %h, actual %h",
						name, r, c, exp.e[n], act.e[n]);
					err_count++;
				end
				// inverse of an SPD matrix must come out exactly symmetric
				if (r < c && act.e[n] !== act.e[c * `MINV_N + r]) begin
					$display("result of %s is not symmetric at (%0d,%0d)", name, r, c);
					err_count++;
				end
			end
		end
	endtask

	always @(posedge i) begin
		if (rst_n && out_valid && out_ready) begin
			compare_result(out_mat);
		end
	end

endmodule

// ==== test/minv_chk.sv ====
// handshake and reset assertions, bound to the inverter top
module minv_chk (
	input logic           i,
	input logic           rst_n,
	input logic           in_valid,
	input logic           in_ready,
	input minv_pkg::mat_t in_mat,
	input logic           out_valid,
	input logic           out_ready,
	input minv_pkg::mat_t out_mat
);

	int fail_count = 0;

	out_hold: assert property (@(posedge i) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_mat))
		else begin
			$error("out_valid or out_mat changed while the output was stalled");
			fail_count++;
		end

	in_hold: assert property (@(posedge i) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_mat))
		else begin
			$error("in_valid or in_mat changed while the input was stalled");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge i) !rst_n |=> !out_valid)
		else begin
			$error("out_valid was high after a reset cycle");
			fail_count++;
		end

	// idle first stage must not start without a transfer
	idle_hold: assert property (@(posedge i) disable iff (!rst_n)
		in_ready && !in_valid |=> in_ready)
		else begin
			$error("in_ready dropped without an input transfer");
			fail_count++;
		end

endmodule

bind minv_top minv_chk chk (.*);

// ==== test/minv_tb.sv ====
// testbench top for the matrix inverter
// clock, reset, pattern file stimulus, out_ready stalls, watchdog and verdict
`include "minv_macros.svh"

module minv_tb;
	import minv_pkg::*;

	localparam int reset_cycles = 16;
	localparam int cycles_per_item = 400;
	localparam int nent = `MINV_N * `MINV_N;

	logic i;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	mat_t in_mat;
	mat_t out_mat;

	string names[$];
	mat_t ins[$];
	mat_t exps[$];
	int limit_cycles = 0;
	int load_errors = 0;
	bit stall_mode = 1'b0;

	minv_top uut (
		.i(i),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_mat(in_mat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_mat(out_mat)
	);

	minv_monitor mon (
		.i(i),
		.rst_n(rst_n),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_mat(out_mat)
	);

	initial begin
		i = 1'b0;
		forever #2 i = ~i;
	end

	// name, nine input words, nine expected words per line
	task automatic load_patterns();
		int fd;
		int cnt;
		string line;
		string name;
		logic [`MINV_W-1:0] w [2*nent];
		mat_t a;
		mat_t e;
		fd = $fopen("test/minv_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file test/minv_patterns.txt");
			load_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8],
				w[9], w[10], w[11], w[12], w[13], w[14], w[15], w[16], w[17]);
			if (cnt != 2 * nent + 1) begin
				$display("malformed line in the pattern file: %s", line);
				load_errors++;
			end else begin
				for (int n = 0; n < nent; n++) begin
					a.e[n] = w[n];
					e.e[n] = w[n + nent];
				end
				names.push_back(name);
				ins.push_back(a);
				exps.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic present_all();
		for (int n = 0; n < names.size(); n++) begin
			mon.expect_result(names[n], exps[n]);
			in_valid = 1'b1;
			in_mat = ins[n];
			while (!in_ready) @(negedge i);
			@(negedge i);
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_results(input int target);
		while (mon.seen < target) @(negedge i);
	endtask

	// out_ready stalls only in the second pass
	initial begin
		void'($urandom(32'h5992_ea42));
		forever begin
			@(negedge i);
			if (stall_mode) out_ready = ($urandom % 3) != 0;
			else out_ready = 1'b1;
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge i);
		$display("timeout: the results did not all arrive within %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_mat = '0;
		out_ready = 1'b1;
		load_patterns();
		if (names.size() == 0) begin
			$display("no usable patterns were read");
			load_errors++;
		end
		limit_cycles = 2 * names.size() * cycles_per_item + reset_cycles + 1;
		repeat (reset_cycles) @(posedge i);
		@(negedge i);
		rst_n = 1'b1;
		@(negedge i);

		// back to back with no back-pressure
		present_all();
		wait_results(names.size());

		// same patterns again under random stalls
		stall_mode = 1'b1;
		present_all();
		wait_results(2 * names.size());
		stall_mode = 1'b0;
		repeat (4) @(negedge i);

		$display("error counts: %0d monitor errors, %0d assertion failures, %0d load errors, %0d results checked",
			mon.err_count, uut.chk.fail_count, load_errors, mon.seen);
		if (mon.err_count == 0 && uut.chk.fail_count == 0 && load_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== test/minv_patterns.txt ====
# name, then input A row-major as nine Q8.8 hex words,
# then the expected inverse row-major as nine Q8.8 hex words
identity 0100 0000 0000 0000 0100 0000 0000 0000 0100 0100 0000 0000 0000 0100 0000 0000 0000 0100
diag_4_1_16 0400 0000 0000 0000 0100 0000 0000 0000 1000 0040 0000 0000 0000 0100 0000 0000 0000 0010
diag_2 0200 0000 0000 0000 0200 0000 0000 0000 0200 007F 0000 0000 0000 007F 0000 0000 0000 007F
diag_4 0400 0000 0000 0000 0400 0000 0000 0000 0400 0040 0000 0000 0000 0040 0000 0000 0000 0040
dense_exact 0400 0200 0200 0200 0500 0300 0200 0300 0600 0054 FFE8 FFF0 FFE8 0050 FFE0 FFF0 FFE0 0040
tridiag 0200 0100 0000 0100 0200 0100 0000 0100 0200 00BD FF80 0040 FF80 00FE FF80 0040 FF80 00C0
dense_again 0400 0200 0200 0200 0500 0300 0200 0300 0600 0054 FFE8 FFF0 FFE8 0050 FFE0 FFF0 FFE0 0040
tridiag_again 0200 0100 0000 0100 0200 0100 0000 0100 0200 00BD FF80 0040 FF80 00FE FF80 0040 FF80 00C0

// ==== project.f ====
+incdir+rtl
rtl/minv_pkg.sv
rtl/fx_div.sv
rtl/fx_sqrt.sv
rtl/chol_stage.sv
rtl/tri_inv_stage.sv
rtl/gram_stage.sv
rtl/minv_top.sv
test/minv_monitor.sv
test/minv_chk.sv
test/minv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module minv_tb -o minv_sim &&
./obj_dir/minv_sim | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
